//--- Bender.yml
package:
  name: csr_unit

sources:
  - rtl/csr_pkg.sv
  - rtl/csr_xfer_pkg.sv
  - rtl/credit_fifo.sv
  - rtl/csr_regfile.sv
  - rtl/csr_exec.sv
  - rtl/csr_unit.sv
  - target: test
    files:
      - tb/csr_unit_tb.sv

//--- rtl/credit_fifo.sv
`default_nettype none

// synchronous FIFO, circular buffer with occupancy count
module credit_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic nrst,
    input  logic push,
    input  T     wdata,
    input  logic pop,
    output T     rdata,
    output logic empty,
    output logic full
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [PW-1:0] wptr;
    logic [PW-1:0] rptr;
    logic [CW-1:0] count;

    assign empty = (count == '0);
    assign full  = (count == CW'(DEPTH));
    assign rdata = mem[rptr];              // head, valid while not empty

    // storage only, no reset needed
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wptr] <= wdata;
    end

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wptr <= (wptr == PW'(DEPTH - 1)) ? '0 : wptr + 1'b1;
            if (pop)
                rptr <= (rptr == PW'(DEPTH - 1)) ? '0 : rptr + 1'b1;

            // simultaneous push and pop leaves count alone
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/csr_exec.sv
`default_nettype none

// executes one queued request per cycle against the register file
module csr_exec
    import csr_pkg::*;
    import csr_xfer_pkg::*;
(
    input  logic            clk,
    input  logic            nrst,
    input  csr_req_t        req,
    input  logic            req_empty,
    output logic            req_pop,
    output logic            req_credit,
    input  logic            rsp_full,
    output csr_rsp_t        rsp,
    output logic            rsp_push,
    output csr_addr_t       rd_addr,
    input  logic [XLEN-1:0] rd_data,
    input  logic            rd_hit,
    output logic            wr_en,
    output csr_addr_t       wr_addr,
    output logic [XLEN-1:0] wr_data,
    output logic            trap_enter,
    output logic [XLEN-1:0] trap_pc,
    output logic [XLEN-1:0] trap_cause,
    output logic [XLEN-1:0] trap_tval,
    output logic            trap_return,
    input  mode_t           current_mode,
    input  logic [XLEN-1:0] mtvec_base,
    input  logic [XLEN-1:0] mepc
);

    logic            fire;
    logic            is_csr;
    logic            illegal;
    logic [XLEN-1:0] new_val;

    // a request goes only when its response has somewhere to land
    assign fire     = !req_empty && !rsp_full;
    assign req_pop  = fire;
    assign rsp_push = fire;

    assign is_csr = (req.kind == CSR_RW) || (req.kind == CSR_RS) || (req.kind == CSR_RC);

    assign rd_addr = req.addr;

    always_comb
    begin
        illegal = 1'b0;
        case (req.kind)
            CSR_RW, CSR_RS, CSR_RC: illegal = !rd_hit || (current_mode == MODE_U);
            TRAP:                   illegal = 1'b0;
            MRET:                   illegal = (current_mode == MODE_U); // M-only instruction
            default:                illegal = 1'b1;
        endcase
    end

    always_comb
    begin
        case (req.kind)
            CSR_RS:  new_val = rd_data | req.operand;
            CSR_RC:  new_val = rd_data & ~req.operand;
            default: new_val = req.operand;
        endcase
    end

    // set and clear with a zero operand are pure reads
    assign wr_en   = fire && is_csr && !illegal &&
                     ((req.kind == CSR_RW) || (req.operand != '0));
    assign wr_addr = req.addr;
    assign wr_data = new_val;

    assign trap_enter  = fire && (req.kind == TRAP);
    assign trap_pc     = req.pc;
    assign trap_cause  = req.cause;
    assign trap_tval   = req.tval;
    assign trap_return = fire && (req.kind == MRET) && !illegal;

    always_comb
    begin
        rsp         = '0;
        rsp.tag     = req.tag;
        rsp.illegal = illegal;
        if (illegal)
            rsp.rdata = CAUSE_ILLEGAL_INSN;   // core takes it as mcause
        else if (is_csr)
            rsp.rdata = rd_data;              // old value
        else if (req.kind == TRAP)
        begin
            rsp.redirect    = 1'b1;
            rsp.redirect_pc = mtvec_base;
        end
        else
        begin
            rsp.redirect    = 1'b1;
            rsp.redirect_pc = mepc;
        end
    end

    // one credit back to the core per request taken
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
            req_credit <= 1'b0;
        else
            req_credit <= fire;
    end

endmodule

`default_nettype wire

//--- rtl/csr_pkg.sv
`default_nettype none

// architectural constants for the machine-mode CSR unit
package csr_pkg;

    parameter int XLEN = 32;

    // only the two modes this core implements
    typedef enum logic [1:0] {
        MODE_U = 2'b00,
        MODE_M = 2'b11
    } mode_t;

    typedef logic [11:0] csr_addr_t;

    // machine information registers, read only
    localparam csr_addr_t CSR_MVENDORID = 12'hF11;
    localparam csr_addr_t CSR_MARCHID   = 12'hF12;
    localparam csr_addr_t CSR_MIMPID    = 12'hF13;
    localparam csr_addr_t CSR_MHARTID   = 12'hF14;

    // machine trap setup
    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MISA      = 12'h301;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;

    // machine trap handling
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MTVAL     = 12'h343;
    localparam csr_addr_t CSR_MIP       = 12'h344;

    // MXL = 1 (32 bit), extensions I, M and U
    localparam logic [XLEN-1:0] MISA_VALUE = {
        2'b01,                          // mxl
        4'b0000,
        26'b00_0001_0000_0001_0001_0000_0000 // U=20, M=12, I=8
    };

    // mstatus, fields at their architectural bit positions
    typedef struct packed {
        logic [12:0] rsvd_31_19;
        logic        sum;               // bit 18
        logic [4:0]  rsvd_17_13;
        mode_t       mpp;               // bits 12:11
        logic [1:0]  rsvd_10_9;
        logic        spp;               // bit 8
        logic        mpie;              // bit 7
        logic        rsvd_6;
        logic        spie;              // bit 5
        logic        rsvd_4;
        logic        mie;               // bit 3
        logic        rsvd_2;
        logic        sie;               // bit 1
        logic        rsvd_0;
    } mstatus_t;

endpackage

`default_nettype wire

//--- rtl/csr_regfile.sv
`default_nettype none

// machine-mode CSR storage with trap entry and return
module csr_regfile
    import csr_pkg::*;
(
    input  logic            clk,
    input  logic            nrst,
    input  logic            irq_ext,
    input  logic            irq_timer,
    input  csr_addr_t       rd_addr,
    output logic [XLEN-1:0] rd_data,
    output logic            rd_hit,
    input  logic            wr_en,
    input  csr_addr_t       wr_addr,
    input  logic [XLEN-1:0] wr_data,
    input  logic            trap_enter,
    input  logic [XLEN-1:0] trap_pc,
    input  logic [XLEN-1:0] trap_cause,
    input  logic [XLEN-1:0] trap_tval,
    input  logic            trap_return,
    output mode_t           current_mode,
    output logic [XLEN-1:0] mtvec_base,
    output logic [XLEN-1:0] mepc,
    output logic            irq_ext_en,
    output logic            irq_timer_en
);

    mode_t             mode_q;
    mstatus_t          mstatus_q;         // only mie, mpie and mpp ever change
    logic              meie_q;
    logic              mtie_q;
    logic              irq_ext_q;         // mip.meip, one cycle behind the line
    logic              irq_timer_q;       // mip.mtip
    logic [XLEN-1:2]   mtvec_q;           // direct mode, base only
    logic [XLEN-1:0]   mscratch_q;
    logic [XLEN-1:2]   mepc_q;
    logic [XLEN-1:0]   mcause_q;
    logic [XLEN-1:0]   mtval_q;

    logic [XLEN-1:0]   mie_word;
    logic [XLEN-1:0]   mip_word;

    assign mie_word = {20'b0, meie_q, 3'b0, mtie_q, 7'b0};
    assign mip_word = {20'b0, irq_ext_q, 3'b0, irq_timer_q, 7'b0};

    assign current_mode = mode_q;
    assign mtvec_base   = {mtvec_q, 2'b00};
    assign mepc         = {mepc_q, 2'b00};

    always_comb
    begin
        rd_hit  = 1'b1;
        rd_data = '0;
        case (rd_addr)
            CSR_MISA:      rd_data = MISA_VALUE;
            CSR_MVENDORID: rd_data = '0;
            CSR_MARCHID:   rd_data = '0;
            CSR_MIMPID:    rd_data = '0;
            CSR_MHARTID:   rd_data = '0;           // single hart
            CSR_MSTATUS:   rd_data = mstatus_q;
            CSR_MIE:       rd_data = mie_word;
            CSR_MIP:       rd_data = mip_word;
            CSR_MTVEC:     rd_data = {mtvec_q, 2'b00};
            CSR_MSCRATCH:  rd_data = mscratch_q;
            CSR_MEPC:      rd_data = {mepc_q, 2'b00};
            CSR_MCAUSE:    rd_data = mcause_q;
            CSR_MTVAL:     rd_data = mtval_q;
            default:       rd_hit  = 1'b0;
        endcase
    end

    // interrupt line sampling for mip
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            irq_ext_q   <= 1'b0;
            irq_timer_q <= 1'b0;
        end
        else
        begin
            irq_ext_q   <= irq_ext;
            irq_timer_q <= irq_timer;
        end
    end

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            mode_q     <= MODE_M;
            mstatus_q  <= '0;                  // mpp resets to U
            meie_q     <= 1'b0;
            mtie_q     <= 1'b0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
        end
        else if (trap_enter)
        begin
            mepc_q         <= trap_pc[XLEN-1:2];
            mcause_q       <= trap_cause;
            mtval_q        <= trap_tval;
            mstatus_q.mpie <= mstatus_q.mie;
            mstatus_q.mie  <= 1'b0;
            mstatus_q.mpp  <= mode_q;
            mode_q         <= MODE_M;
        end
        else if (trap_return)
        begin
            mstatus_q.mie  <= mstatus_q.mpie;
            mstatus_q.mpie <= 1'b1;
            mstatus_q.mpp  <= MODE_U;
            mode_q         <= mstatus_q.mpp;
        end
        else if (wr_en)
        begin
            case (wr_addr)
                CSR_MSTATUS:
                begin
                    mstatus_q.mie  <= wr_data[3];
                    mstatus_q.mpie <= wr_data[7];
                    // unsupported mpp encodings fall back to U
                    mstatus_q.mpp  <= (wr_data[12:11] == MODE_M) ? MODE_M : MODE_U;
                end
                CSR_MIE:
                begin
                    mtie_q <= wr_data[7];
                    meie_q <= wr_data[11];
                end
                CSR_MTVEC:    mtvec_q    <= wr_data[XLEN-1:2];
                CSR_MSCRATCH: mscratch_q <= wr_data;
                CSR_MEPC:     mepc_q     <= wr_data[XLEN-1:2];
                CSR_MCAUSE:   mcause_q   <= wr_data;
                CSR_MTVAL:    mtval_q    <= wr_data;
                default:      ;            // ID registers and mip drop the write
            endcase
        end
    end

    // global enable only gates in M mode, U mode is always interruptible
    assign irq_ext_en   = meie_q & ((mode_q == MODE_M) ? mstatus_q.mie : 1'b1);
    assign irq_timer_en = mtie_q & ((mode_q == MODE_M) ? mstatus_q.mie : 1'b1);

endmodule

`default_nettype wire

//--- rtl/csr_unit.sv
`default_nettype none

// machine-mode CSR unit top, credit based request and response channels
module csr_unit
    import csr_pkg::*;
    import csr_xfer_pkg::*;
#(
    parameter int REQ_DEPTH   = 4,
    parameter int RSP_DEPTH   = 2,
    parameter int RSP_CREDITS = 4
) (
    input  logic     clk,
    input  logic     nrst,
    input  logic     req_valid,
    input  csr_req_t req,
    output logic     req_credit,
    output logic     rsp_valid,
    output csr_rsp_t rsp,
    input  logic     rsp_credit,
    input  logic     irq_ext,
    input  logic     irq_timer,
    output logic     irq_ext_en,
    output logic     irq_timer_en,
    output mode_t    current_mode
);

    localparam int CCW = $clog2(RSP_CREDITS + 1);

    csr_req_t        req_head;
    logic            req_empty;
    logic            req_pop;
    csr_rsp_t        exec_rsp;
    logic            rsp_push;
    logic            rsp_empty;
    logic            rsp_full;
    logic [CCW-1:0]  rsp_credits;

    csr_addr_t       rd_addr;
    logic [XLEN-1:0] rd_data;
    logic            rd_hit;
    logic            wr_en;
    csr_addr_t       wr_addr;
    logic [XLEN-1:0] wr_data;
    logic            trap_enter;
    logic [XLEN-1:0] trap_pc;
    logic [XLEN-1:0] trap_cause;
    logic [XLEN-1:0] trap_tval;
    logic            trap_return;
    logic [XLEN-1:0] mtvec_base;
    logic [XLEN-1:0] mepc;

    // core never sends without a credit, so no full check here
    credit_fifo #(.T(csr_req_t), .DEPTH(REQ_DEPTH)) u_req_q (
        .clk   (clk),
        .nrst  (nrst),
        .push  (req_valid),
        .wdata (req),
        .pop   (req_pop),
        .rdata (req_head),
        .empty (req_empty),
        .full  ()
    );

    csr_exec u_exec (
        .clk          (clk),
        .nrst         (nrst),
        .req          (req_head),
        .req_empty    (req_empty),
        .req_pop      (req_pop),
        .req_credit   (req_credit),
        .rsp_full     (rsp_full),
        .rsp          (exec_rsp),
        .rsp_push     (rsp_push),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .rd_hit       (rd_hit),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .trap_enter   (trap_enter),
        .trap_pc      (trap_pc),
        .trap_cause   (trap_cause),
        .trap_tval    (trap_tval),
        .trap_return  (trap_return),
        .current_mode (current_mode),
        .mtvec_base   (mtvec_base),
        .mepc         (mepc)
    );

    csr_regfile u_regs (
        .clk          (clk),
        .nrst         (nrst),
        .irq_ext      (irq_ext),
        .irq_timer    (irq_timer),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .rd_hit       (rd_hit),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .trap_enter   (trap_enter),
        .trap_pc      (trap_pc),
        .trap_cause   (trap_cause),
        .trap_tval    (trap_tval),
        .trap_return  (trap_return),
        .current_mode (current_mode),
        .mtvec_base   (mtvec_base),
        .mepc         (mepc),
        .irq_ext_en   (irq_ext_en),
        .irq_timer_en (irq_timer_en)
    );

    credit_fifo #(.T(csr_rsp_t), .DEPTH(RSP_DEPTH)) u_rsp_q (
        .clk   (clk),
        .nrst  (nrst),
        .push  (rsp_push),
        .wdata (exec_rsp),
        .pop   (rsp_valid),
        .rdata (rsp),
        .empty (rsp_empty),
        .full  (rsp_full)
    );

    // each beat spends one consumer credit
    assign rsp_valid = !rsp_empty && (rsp_credits != '0);

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
            rsp_credits <= CCW'(RSP_CREDITS);
        else if (rsp_credit && !rsp_valid)
            rsp_credits <= rsp_credits + 1'b1;
        else if (rsp_valid && !rsp_credit)
            rsp_credits <= rsp_credits - 1'b1;
    end

endmodule

`default_nettype wire

//--- rtl/csr_xfer_pkg.sv
`default_nettype none

// request and response formats between the core pipeline and the CSR unit
package csr_xfer_pkg;

    import csr_pkg::*;

    typedef enum logic [2:0] {
        CSR_RW = 3'd0,
        CSR_RS = 3'd1,
        CSR_RC = 3'd2,
        TRAP   = 3'd3,
        MRET   = 3'd4
    } req_kind_t;

    typedef struct packed {
        req_kind_t       kind;
        logic [3:0]      tag;          // core tag, echoed in the response
        csr_addr_t       addr;
        logic [XLEN-1:0] operand;      // rs1 or zimm, already resolved
        logic [XLEN-1:0] pc;           // faulting pc, TRAP only
        logic [XLEN-1:0] cause;        // bit 31 is the interrupt flag
        logic [XLEN-1:0] tval;
    } csr_req_t;

    typedef struct packed {
        logic [3:0]      tag;
        logic [XLEN-1:0] rdata;        // old CSR value, or cause code if illegal
        logic            illegal;
        logic            redirect;
        logic [XLEN-1:0] redirect_pc;
    } csr_rsp_t;

    // illegal instruction, raised by the core on an illegal response
    localparam logic [XLEN-1:0] CAUSE_ILLEGAL_INSN = 32'd2;

endpackage

`default_nettype wire

//--- src.f
rtl/csr_pkg.sv
rtl/csr_xfer_pkg.sv
rtl/credit_fifo.sv
rtl/csr_regfile.sv
rtl/csr_exec.sv
rtl/csr_unit.sv
tb/csr_unit_tb.sv

//--- tb/csr_unit_tb.sv
`default_nettype none

module csr_unit_tb
    import csr_pkg::*;
    import csr_xfer_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int REQ_DEPTH   = 4;
    localparam int RSP_DEPTH   = 2;
    localparam int RSP_CREDITS = 4;
    localparam int TIMEOUT     = 200;      // cycles per wait

    logic     clk = 1'b0;
    logic     nrst;
    logic     req_valid;
    csr_req_t req;
    logic     req_credit;
    logic     rsp_valid;
    csr_rsp_t rsp;
    logic     rsp_credit;
    logic     irq_ext;
    logic     irq_timer;
    logic     irq_ext_en;
    logic     irq_timer_en;
    mode_t    current_mode;

    csr_rsp_t    exp_q [$];                // responses still owed by the DUT
    int          err_cnt;
    int          chk_cnt;
    int          sent;
    int          returned;                 // req_credit pulses seen
    int          owed;                     // rsp credits not yet given back
    bit          hold_credits;
    logic [3:0]  tag_next;
    logic [31:0] rnd_state;
    string       test_name;

    // reference state of the writable fields
    mstatus_t    m_mstatus;
    logic [31:0] m_mie;
    logic [31:0] m_mtvec;
    logic [31:0] m_mscratch;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic [31:0] m_mtval;
    mode_t       m_mode;
    logic        m_irq_ext;
    logic        m_irq_timer;

    csr_unit #(
        .REQ_DEPTH   (REQ_DEPTH),
        .RSP_DEPTH   (RSP_DEPTH),
        .RSP_CREDITS (RSP_CREDITS)
    ) i_dut (
        .clk          (clk),
        .nrst         (nrst),
        .req_valid    (req_valid),
        .req          (req),
        .req_credit   (req_credit),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .rsp_credit   (rsp_credit),
        .irq_ext      (irq_ext),
        .irq_timer    (irq_timer),
        .irq_ext_en   (irq_ext_en),
        .irq_timer_en (irq_timer_en),
        .current_mode (current_mode)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rnd_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rnd_state = x;
        return x;
    endfunction

    function automatic logic model_hit(input csr_addr_t a);
        case (a)
            CSR_MISA, CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID,
            CSR_MSTATUS, CSR_MIE, CSR_MIP, CSR_MTVEC, CSR_MSCRATCH,
            CSR_MEPC, CSR_MCAUSE, CSR_MTVAL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input csr_addr_t a);
        case (a)
            CSR_MISA:     return MISA_VALUE;
            CSR_MSTATUS:  return m_mstatus;
            CSR_MIE:      return m_mie;
            CSR_MIP:      return (m_irq_ext ? 32'h0000_0800 : 32'h0) |  // meip
                                 (m_irq_timer ? 32'h0000_0080 : 32'h0); // mtip
            CSR_MTVEC:    return m_mtvec;
            CSR_MSCRATCH: return m_mscratch;
            CSR_MEPC:     return m_mepc;
            CSR_MCAUSE:   return m_mcause;
            CSR_MTVAL:    return m_mtval;
            default:      return '0;       // ID registers read zero
        endcase
    endfunction

    function automatic void model_write(input csr_addr_t a, input logic [31:0] d);
        case (a)
            CSR_MSTATUS:
            begin
                m_mstatus.mie  = d[3];
                m_mstatus.mpie = d[7];
                m_mstatus.mpp  = (d[12:11] == 2'b11) ? MODE_M : MODE_U; // only M and U exist
            end
            CSR_MIE:      m_mie      = d & 32'h0000_0880;
            CSR_MTVEC:    m_mtvec    = d & ~32'h3;
            CSR_MSCRATCH: m_mscratch = d;
            CSR_MEPC:     m_mepc     = d & ~32'h3;
            CSR_MCAUSE:   m_mcause   = d;
            CSR_MTVAL:    m_mtval    = d;
            default:      ;
        endcase
    endfunction

    task automatic finish_run();
        $display("checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    task automatic give_up(input string what);
        err_cnt++;
        $display("timeout in %s while waiting for %s", test_name, what);
        finish_run();
    endtask

    task automatic check_data(input string what, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        chk_cnt++;
        if (act !== exp)
        begin
            err_cnt++;
            $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_mode(input mode_t exp, input mode_t act);
        chk_cnt++;
        if (act !== exp)
        begin
            err_cnt++;
            $display("CHECK FAILED %s mode: expected %0d, actual %0d", test_name, exp, act);
        end
    endtask

    task automatic check_rsp(input csr_rsp_t exp, input csr_rsp_t act);
        chk_cnt++;
        if (act.tag !== exp.tag || act.illegal !== exp.illegal ||
            act.redirect !== exp.redirect || act.redirect_pc !== exp.redirect_pc)
        begin
            err_cnt++;
            $display("CHECK FAILED %s response: expected tag %h ill %b redir %b pc %h, %s",
                     test_name, exp.tag, exp.illegal, exp.redirect, exp.redirect_pc,
                     $sformatf("actual tag %h ill %b redir %b pc %h",
                               act.tag, act.illegal, act.redirect, act.redirect_pc));
        end
        check_data("rdata", exp.rdata, act.rdata);
    endtask

    // request credits come back as single-cycle pulses
    always @(negedge clk)
    begin
        if (nrst && req_credit)
            returned++;
    end

    // response collector, a beat is seen mid-cycle before the edge that takes it
    always @(negedge clk)
    begin
        if (nrst && rsp_valid)
        begin
            if (exp_q.size() == 0)
            begin
                err_cnt++;
                $display("response with tag %h arrived with no request outstanding", rsp.tag);
            end
            else
                check_rsp(exp_q.pop_front(), rsp);
            owed++;
        end
        if (!hold_credits && owed > 0)
        begin
            rsp_credit = 1'b1;
            owed--;
        end
        else
            rsp_credit = 1'b0;
    end

    task automatic send_req(input csr_req_t r, input csr_rsp_t e);
        int n;
        n = 0;
        @(posedge clk);
        while (REQ_DEPTH + returned - sent <= 0)
        begin
            n++;
            if (n > TIMEOUT)
                give_up("a request credit");
            @(posedge clk);
        end
        @(negedge clk);
        r.tag = tag_next;
        e.tag = tag_next;
        tag_next++;
        req       = r;
        req_valid = 1'b1;
        sent++;
        exp_q.push_back(e);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0)
        begin
            n++;
            if (n > TIMEOUT)
                give_up("outstanding responses");
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic csr_op(input req_kind_t kind, input csr_addr_t a, input logic [31:0] op);
        csr_req_t    r;
        csr_rsp_t    e;
        logic [31:0] old_val;
        logic [31:0] new_val;
        r         = '0;
        r.kind    = kind;
        r.addr    = a;
        r.operand = op;
        e         = '0;
        if (!model_hit(a) || m_mode == MODE_U)
        begin
            e.illegal = 1'b1;
            e.rdata   = CAUSE_ILLEGAL_INSN;
        end
        else
        begin
            old_val = model_read(a);
            e.rdata = old_val;
            case (kind)
                CSR_RS:  new_val = old_val | op;
                CSR_RC:  new_val = old_val & ~op;
                default: new_val = op;
            endcase
            if (kind == CSR_RW || op != '0)     // set/clear with zero only reads
                model_write(a, new_val);
        end
        send_req(r, e);
    endtask

    task automatic trap_op(input logic [31:0] pc, input logic [31:0] cause,
                           input logic [31:0] tval);
        csr_req_t r;
        csr_rsp_t e;
        r             = '0;
        r.kind        = TRAP;
        r.pc          = pc;
        r.cause       = cause;
        r.tval        = tval;
        e             = '0;
        e.redirect    = 1'b1;
        e.redirect_pc = m_mtvec;
        m_mepc         = pc & ~32'h3;
        m_mcause       = cause;
        m_mtval        = tval;
        m_mstatus.mpie = m_mstatus.mie;
        m_mstatus.mie  = 1'b0;
        m_mstatus.mpp  = m_mode;
        m_mode         = MODE_M;
        send_req(r, e);
    endtask

    task automatic mret_op();
        csr_req_t r;
        csr_rsp_t e;
        r             = '0;
        r.kind        = MRET;
        e             = '0;
        e.redirect    = 1'b1;
        e.redirect_pc = m_mepc;
        m_mstatus.mie  = m_mstatus.mpie;
        m_mstatus.mpie = 1'b1;
        m_mode         = m_mstatus.mpp;
        m_mstatus.mpp  = MODE_U;
        send_req(r, e);
    endtask

    task automatic check_enables();
        logic [31:0] exp;
        if (m_mode == MODE_U)
            exp = {30'b0, m_mie[11], m_mie[7]};  // individual enables decide alone
        else
            exp = {30'b0, m_mie[11] && m_mstatus.mie, m_mie[7] && m_mstatus.mie};
        check_data("irq enables", exp, {30'b0, irq_ext_en, irq_timer_en});
    endtask

    task automatic set_irq(input logic ext, input logic tim);
        @(negedge clk);
        irq_ext     = ext;
        irq_timer   = tim;
        m_irq_ext   = ext;
        m_irq_timer = tim;
        repeat (2) @(negedge clk);         // let mip sample the lines
    endtask

    task automatic rmw_reg(input csr_addr_t a);
        csr_op(CSR_RW, a, next_rand());
        csr_op(CSR_RS, a, next_rand());
        csr_op(CSR_RC, a, next_rand());
        csr_op(CSR_RS, a, '0);
    endtask

    task automatic test_reset_ids();
        test_name = "reset_ids";
        check_mode(MODE_M, current_mode);
        check_enables();
        csr_op(CSR_RS, CSR_MISA, '0);
        csr_op(CSR_RS, CSR_MVENDORID, '0);
        csr_op(CSR_RS, CSR_MARCHID, '0);
        csr_op(CSR_RS, CSR_MIMPID, '0);
        csr_op(CSR_RS, CSR_MHARTID, '0);
        csr_op(CSR_RS, CSR_MSTATUS, '0);
        csr_op(CSR_RS, CSR_MIE, '0);
        csr_op(CSR_RS, CSR_MEPC, '0);
        csr_op(CSR_RS, CSR_MCAUSE, '0);
        wait_drain();
    endtask

    task automatic test_rmw();
        test_name = "rmw";
        rmw_reg(CSR_MSCRATCH);
        rmw_reg(CSR_MTVEC);
        rmw_reg(CSR_MEPC);
        rmw_reg(CSR_MIE);
        rmw_reg(CSR_MSTATUS);
        csr_op(CSR_RW, CSR_MISA, next_rand());  // read only, value must stay
        csr_op(CSR_RS, CSR_MISA, '0);
        wait_drain();
    endtask

    task automatic test_illegal();
        test_name = "illegal";
        csr_op(CSR_RW, 12'h7C0, next_rand());
        csr_op(CSR_RS, 12'h7C0, '0);
        csr_op(CSR_RS, CSR_MSCRATCH, '0);
        csr_op(CSR_RS, CSR_MSTATUS, '0);
        wait_drain();
    endtask

    task automatic test_trap();
        test_name = "trap";
        csr_op(CSR_RS, CSR_MSTATUS, 32'h0000_0008);
        csr_op(CSR_RW, CSR_MTVEC, 32'h0000_0100);
        trap_op(next_rand() & ~32'h3, 32'd11, next_rand());
        csr_op(CSR_RS, CSR_MEPC, '0);
        csr_op(CSR_RS, CSR_MCAUSE, '0);
        csr_op(CSR_RS, CSR_MTVAL, '0);
        csr_op(CSR_RS, CSR_MSTATUS, '0);       // mie 0, mpie 1, mpp M
        wait_drain();
        check_mode(MODE_M, current_mode);
        csr_op(CSR_RC, CSR_MSTATUS, 32'h0000_1800);
        csr_op(CSR_RW, CSR_MEPC, 32'h0000_4000);
        mret_op();
        wait_drain();
        check_mode(MODE_U, current_mode);
        csr_op(CSR_RS, CSR_MSCRATCH, '0);      // no CSR access from U
        trap_op(32'h0000_4004, 32'd8, '0);
        csr_op(CSR_RS, CSR_MSTATUS, '0);
        wait_drain();
        check_mode(MODE_M, current_mode);
    endtask

    task automatic test_irq();
        test_name = "irq";
        csr_op(CSR_RW, CSR_MIE, 32'h0000_0880);
        csr_op(CSR_RS, CSR_MSTATUS, 32'h0000_0008);
        wait_drain();
        check_enables();
        set_irq(1'b1, 1'b0);
        csr_op(CSR_RS, CSR_MIP, '0);
        set_irq(1'b0, 1'b1);
        csr_op(CSR_RS, CSR_MIP, '0);
        csr_op(CSR_RC, CSR_MSTATUS, 32'h0000_0088); // mie and mpie both cleared
        wait_drain();
        check_enables();
        csr_op(CSR_RC, CSR_MIE, 32'h0000_0080);
        mret_op();                             // mpp is U here
        wait_drain();
        check_mode(MODE_U, current_mode);
        check_enables();
        trap_op(32'h0000_2000, 32'h8000_0007, '0);
        set_irq(1'b0, 1'b0);
        wait_drain();
        check_mode(MODE_M, current_mode);
        check_enables();
    endtask

    task automatic test_backpressure();
        int n;
        test_name = "backpressure";
        @(posedge clk);
        hold_credits = 1'b1;
        repeat (REQ_DEPTH + RSP_DEPTH + RSP_CREDITS)
            csr_op(CSR_RW, CSR_MSCRATCH, next_rand());
        n = 0;
        while (owed < RSP_CREDITS)
        begin
            n++;
            if (n > TIMEOUT)
                give_up("the first responses");
            @(negedge clk);
        end
        repeat (20)
        begin
            @(negedge clk);
            if (rsp_valid)
            begin
                err_cnt++;
                $display("rsp_valid went high with no response credit left");
            end
        end
        // a full request queue keeps its REQ_DEPTH credits
        check_data("req credits while stalled", sent - REQ_DEPTH, returned);
        check_data("queued responses", REQ_DEPTH + RSP_DEPTH, exp_q.size());
        @(posedge clk);
        hold_credits = 1'b0;
        csr_op(CSR_RS, CSR_MSCRATCH, '0);
        wait_drain();
    endtask

    initial
    begin
        nrst         = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        rsp_credit   = 1'b0;
        irq_ext      = 1'b0;
        irq_timer    = 1'b0;
        hold_credits = 1'b0;
        err_cnt      = 0;
        chk_cnt      = 0;
        sent         = 0;
        returned     = 0;
        owed         = 0;
        tag_next     = '0;
        rnd_state    = 32'd10792;
        test_name    = "setup";
        m_mstatus    = '0;
        m_mie        = '0;
        m_mtvec      = '0;
        m_mscratch   = '0;
        m_mepc       = '0;
        m_mcause     = '0;
        m_mtval      = '0;
        m_mode       = MODE_M;
        m_irq_ext    = 1'b0;
        m_irq_timer  = 1'b0;
        repeat (3) @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);
        test_reset_ids();
        test_rmw();
        test_illegal();
        test_trap();
        test_irq();
        test_backpressure();
        finish_run();
    end

endmodule

`default_nettype wire
